// ==== source/edp_params.svh ====
// EDP parameters for word widths, fast memory depth and the APB register map
`ifndef EDP_PARAMS_SVH
`define EDP_PARAMS_SVH

`define EDP_WORD_W 36
`define EDP_HALF_W 18
`define EDP_FM_AW  4
`define EDP_APB_AW 8
`define EDP_APB_DW 32

`define EDP_REG_IMM_LO 8'h00
`define EDP_REG_IMM_HI 8'h04
`define EDP_REG_MICRO  8'h08
`define EDP_REG_STATUS 8'h0C
`define EDP_REG_RDSEL  8'h10
`define EDP_REG_RD_LO  8'h14
`define EDP_REG_RD_HI  8'h18

`endif

// ==== source/edpPkg.sv ====
// EDP package with the micro-word select and operation types and field positions
package edpPkg;

  typedef enum logic [1:0] {ADA_AR, ADA_ARX, ADA_MQ, ADA_ZERO} adaSel_t;

  // BR_X2 is BR shifted left one place with BRX bit 0 spliced in
  typedef enum logic [1:0] {ADB_FM, ADB_BR, ADB_BR_X2, ADB_ARX} adbSel_t;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS_A, ALU_PASS_B, ALU_NOT_A
  } aluOp_t;

  typedef enum logic [2:0] {
    AR_IMM, AR_AD, AR_FM, AR_ARX, AR_MQ, AR_AD_LEFT, AR_AD_RIGHT, AR_ZERO
  } arSel_t;

  typedef enum logic [1:0] {ARX_ZERO, ARX_IMM, ARX_AD, ARX_MQ} arxSel_t;
  typedef enum logic [1:0] {MQ_HOLD, MQ_LOAD, MQ_SHIFT_LEFT, MQ_SHIFT_RIGHT} mqOp_t;
  typedef enum logic [1:0] {MQM_AD, MQM_IMM, MQM_ONES, MQM_ARX} mqmSel_t;

  typedef enum logic [2:0] {RD_AR, RD_ARX, RD_BR, RD_BRX, RD_MQ, RD_FM, RD_AD} rdSel_t;

  // Micro-word field positions in pwdata, counted from the LSB
  localparam int MW_ALU_OP     = 0;
  localparam int MW_CARRY_IN   = 3;
  localparam int MW_ADA_SEL    = 4;
  localparam int MW_ADB_SEL    = 6;
  localparam int MW_AR_SEL     = 8;
  localparam int MW_AR_LOAD    = 11;
  localparam int MW_ARX_SEL    = 12;
  localparam int MW_ARX_LOAD   = 14;
  localparam int MW_BR_LOAD    = 15;
  localparam int MW_BRX_LOAD   = 16;
  localparam int MW_MQ_OP      = 17;
  localparam int MW_MQM_SEL    = 19;
  localparam int MW_FM_ADDR    = 21;
  localparam int MW_FM_WRITE_L = 25;
  localparam int MW_FM_WRITE_R = 26;
  localparam int MW_WIDTH      = 27;

endpackage

// ==== source/fastMemory.sv ====
// Fast memory: 16-word register array with halfword write enables and a reset clear walk
`timescale 1ns/10ps
`include "edp_params.svh"

module fastMemory (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`EDP_FM_AW-1:0]  addr,
  input  logic [0:`EDP_WORD_W-1] wdata,
  input  logic                   writeL,
  input  logic                   writeR,
  output logic [0:`EDP_WORD_W-1] rdata,
  output logic                   clearBusy
);

  logic [0:`EDP_WORD_W-1] mem [0:(1 << `EDP_FM_AW)-1];
  logic [`EDP_FM_AW-1:0]  clearAddr;

  // Clear walk runs one word per cycle once reset drops
  always_ff @(posedge clk) begin
    if (rst) begin
      clearBusy <= 1'b1;
      clearAddr <= '0;
    end else if (clearBusy) begin
      clearAddr <= clearAddr + 1'b1;
      if (clearAddr == '1) clearBusy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst && clearBusy) begin
      mem[clearAddr] <= '0;
    end else begin
      if (writeL) mem[addr][0:`EDP_HALF_W-1] <= wdata[0:`EDP_HALF_W-1];
      if (writeR) mem[addr][`EDP_HALF_W:`EDP_WORD_W-1] <= wdata[`EDP_HALF_W:`EDP_WORD_W-1];
    end
  end

  assign rdata = mem[addr];

endmodule

// ==== source/adderUnit.sv ====
// Adder unit: 36-bit arithmetic and boolean function with carry out and overflow
`timescale 1ns/10ps
`include "edp_params.svh"

module adderUnit import edpPkg::*; (
  input  logic [0:`EDP_WORD_W-1] adA,
  input  logic [0:`EDP_WORD_W-1] adB,
  input  aluOp_t                 aluOp,
  input  logic                   carryIn,
  output logic [0:`EDP_WORD_W-1] ad,
  output logic                   carryOut,
  output logic                   overflow
);

  logic [0:`EDP_WORD_W-1] opB;
  logic                   cin;
  logic [0:`EDP_WORD_W]   sumWide;
  logic                   isArith;

  assign isArith = (aluOp == ALU_ADD) || (aluOp == ALU_SUB);

  // Subtract is A plus the complement of B plus one
  always_comb begin
    if (aluOp == ALU_SUB) begin
      opB = ~adB;
      cin = 1'b1;
    end else begin
      opB = adB;
      cin = carryIn;
    end
  end

  // Extra top bit catches the carry out of bit 0
  assign sumWide = {1'b0, adA} + {1'b0, opB} + {{`EDP_WORD_W{1'b0}}, cin};

  always_comb begin
    case (aluOp)
      ALU_ADD,
      ALU_SUB:    ad = sumWide[1:`EDP_WORD_W];
      ALU_AND:    ad = adA & adB;
      ALU_OR:     ad = adA | adB;
      ALU_XOR:    ad = adA ^ adB;
      ALU_PASS_A: ad = adA;
      ALU_PASS_B: ad = adB;
      default:    ad = ~adA;
    endcase
  end

  // Boolean ops never carry or overflow
  always_comb begin
    if (isArith) begin
      carryOut = sumWide[0];
      overflow = (adA[0] == opB[0]) && (ad[0] != adA[0]);
    end else begin
      carryOut = 1'b0;
      overflow = 1'b0;
    end
  end

endmodule

// ==== source/mqShifter.sv ====
// MQ shifter: universal shift register with the MQM parallel-load mux
`timescale 1ns/10ps
`include "edp_params.svh"

module mqShifter import edpPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  mqOp_t                  mqOp,
  input  mqmSel_t                mqmSel,
  input  logic [0:`EDP_WORD_W-1] ad,
  input  logic [0:`EDP_WORD_W-1] imm,
  input  logic [0:`EDP_WORD_W-1] arx,
  input  logic                   carryOut,
  output logic [0:`EDP_WORD_W-1] mq
);

  logic [0:`EDP_WORD_W-1] mqm;

  always_comb begin
    case (mqmSel)
      MQM_AD:   mqm = ad;
      MQM_IMM:  mqm = imm;
      MQM_ONES: mqm = '1;
      default:  mqm = arx;
    endcase
  end

  // Left shift fills bit 35 from the AD carry, right shift keeps the sign
  always_ff @(posedge clk) begin
    if (rst) begin
      mq <= '0;
    end else begin
      case (mqOp)
        MQ_LOAD:        mq <= mqm;
        MQ_SHIFT_LEFT:  mq <= {mq[1:`EDP_WORD_W-1], carryOut};
        MQ_SHIFT_RIGHT: mq <= {mq[0], mq[0:`EDP_WORD_W-2]};
        default:        mq <= mq;
      endcase
    end
  end

endmodule

// ==== source/registerPath.sv ====
// Register path: AR, ARX, BR and BRX with their input muxes and the AD operand muxes
`timescale 1ns/10ps
`include "edp_params.svh"

module registerPath import edpPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [0:`EDP_WORD_W-1] imm,
  input  logic [0:`EDP_WORD_W-1] ad,
  input  logic [0:`EDP_WORD_W-1] fm,
  input  logic [0:`EDP_WORD_W-1] mq,
  input  adaSel_t                adaSel,
  input  adbSel_t                adbSel,
  input  arSel_t                 arSel,
  input  arxSel_t                arxSel,
  input  logic                   arLoad,
  input  logic                   arxLoad,
  input  logic                   brLoad,
  input  logic                   brxLoad,
  output logic [0:`EDP_WORD_W-1] ar,
  output logic [0:`EDP_WORD_W-1] arx,
  output logic [0:`EDP_WORD_W-1] br,
  output logic [0:`EDP_WORD_W-1] brx,
  output logic [0:`EDP_WORD_W-1] adA,
  output logic [0:`EDP_WORD_W-1] adB
);

  logic [0:`EDP_WORD_W-1] arM;
  logic [0:`EDP_WORD_W-1] arxM;

  // AR input mux
  always_comb begin
    case (arSel)
      AR_IMM:      arM = imm;
      AR_AD:       arM = ad;
      AR_FM:       arM = fm;
      AR_ARX:      arM = arx;
      AR_MQ:       arM = mq;
      AR_AD_LEFT:  arM = {ad[1:`EDP_WORD_W-1], 1'b0};
      AR_AD_RIGHT: arM = {ad[0], ad[0:`EDP_WORD_W-2]};
      default:     arM = '0;
    endcase
  end

  // ARX input mux
  always_comb begin
    case (arxSel)
      ARX_IMM: arxM = imm;
      ARX_AD:  arxM = ad;
      ARX_MQ:  arxM = mq;
      default: arxM = '0;
    endcase
  end

  // BR and BRX copy AR and ARX as they were before the edge
  always_ff @(posedge clk) begin
    if (rst) begin
      ar  <= '0;
      arx <= '0;
      br  <= '0;
      brx <= '0;
    end else begin
      if (arLoad) ar <= arM;
      if (arxLoad) arx <= arxM;
      if (brLoad) br <= ar;
      if (brxLoad) brx <= arx;
    end
  end

  // ADA mux
  always_comb begin
    case (adaSel)
      ADA_AR:  adA = ar;
      ADA_ARX: adA = arx;
      ADA_MQ:  adA = mq;
      default: adA = '0;
    endcase
  end

  // ADB mux, BR*2 takes its low bit from BRX bit 0
  always_comb begin
    case (adbSel)
      ADB_FM:    adB = fm;
      ADB_BR:    adB = br;
      ADB_BR_X2: adB = {br[1:`EDP_WORD_W-1], brx[0]};
      default:   adB = arx;
    endcase
  end

endmodule

// ==== source/edpControl.sv ====
// EDP control: APB slave, micro-word decode into step strobes, flags and readout mux
`timescale 1ns/10ps
`include "edp_params.svh"

module edpControl import edpPkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`EDP_APB_AW-1:0]  paddr,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [`EDP_APB_DW-1:0]  pwdata,
  output logic [`EDP_APB_DW-1:0]  prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic [0:`EDP_WORD_W-1]  imm,
  output adaSel_t                 adaSel,
  output adbSel_t                 adbSel,
  output aluOp_t                  aluOp,
  output logic                    carryIn,
  output arSel_t                  arSel,
  output arxSel_t                 arxSel,
  output mqmSel_t                 mqmSel,
  output mqOp_t                   mqOp,
  output logic                    arLoad,
  output logic                    arxLoad,
  output logic                    brLoad,
  output logic                    brxLoad,
  output logic [`EDP_FM_AW-1:0]   fmAddr,
  output logic                    fmWriteL,
  output logic                    fmWriteR,
  input  logic                    fmClearBusy,
  input  logic                    carryOut,
  input  logic                    overflow,
  input  logic [0:`EDP_WORD_W-1]  ad,
  input  logic [0:`EDP_WORD_W-1]  ar,
  input  logic [0:`EDP_WORD_W-1]  arx,
  input  logic [0:`EDP_WORD_W-1]  br,
  input  logic [0:`EDP_WORD_W-1]  brx,
  input  logic [0:`EDP_WORD_W-1]  mq,
  input  logic [0:`EDP_WORD_W-1]  fm
);

  logic                   access;
  logic                   isImmLo;
  logic                   isImmHi;
  logic                   isMicro;
  logic                   isStatus;
  logic                   isRdSel;
  logic                   isRdLo;
  logic                   isRdHi;
  logic                   badAccess;
  logic                   wrEn;
  logic                   stepNow;
  logic                   stepDone;
  logic [MW_WIDTH-1:0]    microReg;
  logic [MW_WIDTH-1:0]    microWord;
  rdSel_t                 rdSel;
  logic                   carryFlag;
  logic                   overflowFlag;
  logic                   zeroFlag;
  logic [0:`EDP_WORD_W-1] rdWord;

  assign access = psel & penable;

  always_comb begin
    isImmLo  = (paddr == `EDP_REG_IMM_LO);
    isImmHi  = (paddr == `EDP_REG_IMM_HI);
    isMicro  = (paddr == `EDP_REG_MICRO);
    isStatus = (paddr == `EDP_REG_STATUS);
    isRdSel  = (paddr == `EDP_REG_RDSEL);
    isRdLo   = (paddr == `EDP_REG_RD_LO);
    isRdHi   = (paddr == `EDP_REG_RD_HI);
  end

  // Unmapped, write to a read-only register, or read of MICRO
  assign badAccess = ~(isImmLo | isImmHi | isMicro | isStatus | isRdSel | isRdLo | isRdHi)
                   | (pwrite & (isStatus | isRdLo | isRdHi))
                   | (~pwrite & isMicro);

  // MICRO writes hold off for one wait state, everything waits for the FM clear
  always_comb begin
    if (!access || fmClearBusy) begin
      pready = 1'b0;
    end else if (isMicro && pwrite) begin
      pready = stepDone;
    end else begin
      pready = 1'b1;
    end
  end

  assign pslverr = pready & badAccess;
  assign wrEn    = access & pwrite & ~fmClearBusy & ~badAccess & ~isMicro;
  assign stepNow = access & pwrite & isMicro & ~stepDone & ~fmClearBusy;

  always_ff @(posedge clk) begin
    if (rst) begin
      stepDone <= 1'b0;
    end else if (stepNow) begin
      stepDone <= 1'b1;
    end else if (pready || !access) begin
      stepDone <= 1'b0;
    end
  end

  // Step cycle takes selects straight from pwdata, later cycles from the held word
  assign microWord = stepNow ? pwdata[MW_WIDTH-1:0] : microReg;

  always_ff @(posedge clk) begin
    if (rst) begin
      microReg <= '0;
    end else if (stepNow) begin
      microReg <= pwdata[MW_WIDTH-1:0];
    end
  end

  assign aluOp   = aluOp_t'(microWord[MW_ALU_OP +: 3]);
  assign carryIn = microWord[MW_CARRY_IN];
  assign adaSel  = adaSel_t'(microWord[MW_ADA_SEL +: 2]);
  assign adbSel  = adbSel_t'(microWord[MW_ADB_SEL +: 2]);
  assign arSel   = arSel_t'(microWord[MW_AR_SEL +: 3]);
  assign arxSel  = arxSel_t'(microWord[MW_ARX_SEL +: 2]);
  assign mqmSel  = mqmSel_t'(microWord[MW_MQM_SEL +: 2]);
  assign fmAddr  = microWord[MW_FM_ADDR +: `EDP_FM_AW];

  // One-cycle strobes
  assign arLoad   = stepNow & microWord[MW_AR_LOAD];
  assign arxLoad  = stepNow & microWord[MW_ARX_LOAD];
  assign brLoad   = stepNow & microWord[MW_BR_LOAD];
  assign brxLoad  = stepNow & microWord[MW_BRX_LOAD];
  assign fmWriteL = stepNow & microWord[MW_FM_WRITE_L];
  assign fmWriteR = stepNow & microWord[MW_FM_WRITE_R];
  assign mqOp     = stepNow ? mqOp_t'(microWord[MW_MQ_OP +: 2]) : MQ_HOLD;

  always_ff @(posedge clk) begin
    if (rst) begin
      imm   <= '0;
      rdSel <= RD_AR;
    end else if (wrEn) begin
      if (isImmLo) imm[`EDP_HALF_W:`EDP_WORD_W-1] <= pwdata[`EDP_HALF_W-1:0];
      if (isImmHi) imm[0:`EDP_HALF_W-1] <= pwdata[`EDP_HALF_W-1:0];
      if (isRdSel) rdSel <= rdSel_t'(pwdata[2:0]);
    end
  end

  // Flags sample the AD result at the step edge
  always_ff @(posedge clk) begin
    if (rst) begin
      carryFlag    <= 1'b0;
      overflowFlag <= 1'b0;
      zeroFlag     <= 1'b0;
    end else if (stepNow) begin
      carryFlag    <= carryOut;
      overflowFlag <= overflow;
      zeroFlag     <= (ad == '0);
    end
  end

  // Diagnostic readout, stands in for the EBUS
  always_comb begin
    case (rdSel)
      RD_AR:   rdWord = ar;
      RD_ARX:  rdWord = arx;
      RD_BR:   rdWord = br;
      RD_BRX:  rdWord = brx;
      RD_MQ:   rdWord = mq;
      RD_FM:   rdWord = fm;
      RD_AD:   rdWord = ad;
      default: rdWord = '0;
    endcase
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (isImmLo) prdata[`EDP_HALF_W-1:0] = imm[`EDP_HALF_W:`EDP_WORD_W-1];
      if (isImmHi) prdata[`EDP_HALF_W-1:0] = imm[0:`EDP_HALF_W-1];
      if (isStatus) prdata[3:0] = {^fm, zeroFlag, overflowFlag, carryFlag};
      if (isRdSel) prdata[2:0] = rdSel;
      if (isRdLo) prdata[`EDP_HALF_W-1:0] = rdWord[`EDP_HALF_W:`EDP_WORD_W-1];
      if (isRdHi) prdata[`EDP_HALF_W-1:0] = rdWord[0:`EDP_HALF_W-1];
    end
  end

endmodule

// ==== source/edpTop.sv ====
// EDP top level: APB control wired to the register path, adder, MQ and fast memory
`timescale 1ns/10ps
`include "edp_params.svh"

module edpTop import edpPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`EDP_APB_AW-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`EDP_APB_DW-1:0] pwdata,
  output logic [`EDP_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);

  logic [0:`EDP_WORD_W-1] imm;
  logic [0:`EDP_WORD_W-1] ad;
  logic [0:`EDP_WORD_W-1] ar;
  logic [0:`EDP_WORD_W-1] arx;
  logic [0:`EDP_WORD_W-1] br;
  logic [0:`EDP_WORD_W-1] brx;
  logic [0:`EDP_WORD_W-1] mq;
  logic [0:`EDP_WORD_W-1] fm;
  logic [0:`EDP_WORD_W-1] adA;
  logic [0:`EDP_WORD_W-1] adB;
  adaSel_t                adaSel;
  adbSel_t                adbSel;
  aluOp_t                 aluOp;
  arSel_t                 arSel;
  arxSel_t                arxSel;
  mqmSel_t                mqmSel;
  mqOp_t                  mqOp;
  logic                   carryIn;
  logic                   carryOut;
  logic                   overflow;
  logic                   arLoad;
  logic                   arxLoad;
  logic                   brLoad;
  logic                   brxLoad;
  logic [`EDP_FM_AW-1:0]  fmAddr;
  logic                   fmWriteL;
  logic                   fmWriteR;
  logic                   fmClearBusy;

  edpControl u_edpControl (
    .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .imm(imm), .adaSel(adaSel), .adbSel(adbSel), .aluOp(aluOp),
    .carryIn(carryIn), .arSel(arSel), .arxSel(arxSel), .mqmSel(mqmSel), .mqOp(mqOp),
    .arLoad(arLoad), .arxLoad(arxLoad), .brLoad(brLoad), .brxLoad(brxLoad),
    .fmAddr(fmAddr), .fmWriteL(fmWriteL), .fmWriteR(fmWriteR),
    .fmClearBusy(fmClearBusy), .carryOut(carryOut), .overflow(overflow),
    .ad(ad), .ar(ar), .arx(arx), .br(br), .brx(brx), .mq(mq), .fm(fm)
  );

  registerPath u_registerPath (
    .clk(clk), .rst(rst), .imm(imm), .ad(ad), .fm(fm), .mq(mq),
    .adaSel(adaSel), .adbSel(adbSel), .arSel(arSel), .arxSel(arxSel),
    .arLoad(arLoad), .arxLoad(arxLoad), .brLoad(brLoad), .brxLoad(brxLoad),
    .ar(ar), .arx(arx), .br(br), .brx(brx), .adA(adA), .adB(adB)
  );

  adderUnit u_adderUnit (
    .adA(adA), .adB(adB), .aluOp(aluOp), .carryIn(carryIn),
    .ad(ad), .carryOut(carryOut), .overflow(overflow)
  );

  mqShifter u_mqShifter (
    .clk(clk), .rst(rst), .mqOp(mqOp), .mqmSel(mqmSel), .ad(ad), .imm(imm),
    .arx(arx), .carryOut(carryOut), .mq(mq)
  );

  // FM always stores AR
  fastMemory u_fastMemory (
    .clk(clk), .rst(rst), .addr(fmAddr), .wdata(ar), .writeL(fmWriteL),
    .writeR(fmWriteR), .rdata(fm), .clearBusy(fmClearBusy)
  );

endmodule

// ==== sim/edpTb.sv ====
// EDP testbench: APB-driven microsteps checked against a register-level reference model
`timescale 1ns/10ps
`include "edp_params.svh"

module edpTb import edpPkg::*; ();

  localparam int APB_TIMEOUT = 64;

  logic                   clk;
  logic                   rst;
  logic [`EDP_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`EDP_APB_DW-1:0] pwdata;
  logic [`EDP_APB_DW-1:0] prdata;
  logic                   pready;
  logic                   pslverr;

  int          errorCount;
  int          testsRun;
  int          testsFailed;
  int          testStartErrors;
  bit          walkDone;
  logic [31:0] lcgState;

  // Reference model state with bit 35 as the word's most significant bit
  logic [35:0] mAr, mArx, mBr, mBrx, mMq, mImm;
  logic [35:0] mFm [16];
  logic        mCarry, mOvf, mZero;

  // Fields of the next micro-word
  aluOp_t  uOp;
  adaSel_t uAda;
  adbSel_t uAdb;
  arSel_t  uArSel;
  arxSel_t uArxSel;
  mqOp_t   uMqOp;
  mqmSel_t uMqm;
  logic    uCin, uArLoad, uArxLoad, uBrLoad, uBrxLoad, uWl, uWr;
  logic [3:0] uFmAddr;

  // Selects of the last executed micro-word, which the readout keeps using
  aluOp_t     lastOp;
  adaSel_t    lastAda;
  adbSel_t    lastAdb;
  logic       lastCin;
  logic [3:0] lastFmAddr;

  edpTop u_edpTop (
    .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr)
  );

  always #5 clk = ~clk;

  assert property (@(posedge clk) disable iff (rst) pslverr |-> pready)
    else begin
      $display("ERROR %0t: pslverr high without pready", $time);
      errorCount++;
    end

  // Setup phase alone must never complete a transfer
  assert property (@(posedge clk) disable iff (rst) (psel && !penable) |-> !pready)
    else begin
      $display("ERROR %0t: pready high in the APB setup phase", $time);
      errorCount++;
    end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [35:0] randWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRand();
    lo = nextRand();
    return {hi[31:14], lo[31:14]};
  endfunction

  // Returns carry, overflow and the 36-bit result
  function automatic logic [37:0] refAlu(input aluOp_t op, input logic [35:0] a,
                                         input logic [35:0] b, input logic cin);
    logic [36:0] sum;
    logic [35:0] bb;
    logic [35:0] res;
    bb = (op == ALU_SUB) ? ~b : b;
    sum = {1'b0, a} + {1'b0, bb} + ((op == ALU_SUB) ? 37'd1 : {36'd0, cin});
    case (op)
      ALU_AND:    res = a & b;
      ALU_OR:     res = a | b;
      ALU_XOR:    res = a ^ b;
      ALU_PASS_A: res = a;
      ALU_PASS_B: res = b;
      ALU_NOT_A:  res = ~a;
      default:    res = sum[35:0];
    endcase
    if (op != ALU_ADD && op != ALU_SUB) return {2'b00, res};
    return {sum[36], (a[35] == bb[35]) && (res[35] != a[35]), res};
  endfunction

  function automatic logic [35:0] refAda(input adaSel_t sel);
    case (sel)
      ADA_AR:  return mAr;
      ADA_ARX: return mArx;
      ADA_MQ:  return mMq;
      default: return 36'd0;
    endcase
  endfunction

  function automatic logic [35:0] refAdb(input adbSel_t sel, input logic [3:0] addr);
    case (sel)
      ADB_FM:    return mFm[addr];
      ADB_BR:    return mBr;
      ADB_BR_X2: return {mBr[34:0], mBrx[35]};
      default:   return mArx;
    endcase
  endfunction

  function automatic logic [35:0] refReadout(input rdSel_t sel);
    logic [37:0] r;
    r = refAlu(lastOp, refAda(lastAda), refAdb(lastAdb, lastFmAddr), lastCin);
    case (sel)
      RD_AR:   return mAr;
      RD_ARX:  return mArx;
      RD_BR:   return mBr;
      RD_BRX:  return mBrx;
      RD_MQ:   return mMq;
      RD_FM:   return mFm[lastFmAddr];
      default: return r[35:0];
    endcase
  endfunction

  function automatic logic [31:0] packMicro();
    logic [31:0] w;
    w = '0;
    w[MW_ALU_OP +: 3] = uOp;
    w[MW_CARRY_IN] = uCin;
    w[MW_ADA_SEL +: 2] = uAda;
    w[MW_ADB_SEL +: 2] = uAdb;
    w[MW_AR_SEL +: 3] = uArSel;
    w[MW_AR_LOAD] = uArLoad;
    w[MW_ARX_SEL +: 2] = uArxSel;
    w[MW_ARX_LOAD] = uArxLoad;
    w[MW_BR_LOAD] = uBrLoad;
    w[MW_BRX_LOAD] = uBrxLoad;
    w[MW_MQ_OP +: 2] = uMqOp;
    w[MW_MQM_SEL +: 2] = uMqm;
    w[MW_FM_ADDR +: 4] = uFmAddr;
    w[MW_FM_WRITE_L] = uWl;
    w[MW_FM_WRITE_R] = uWr;
    return w;
  endfunction

  task automatic clearMicro();
    uOp = ALU_PASS_A;
    uAda = ADA_AR;
    uAdb = ADB_BR;
    uArSel = AR_IMM;
    uArxSel = ARX_ZERO;
    uMqOp = MQ_HOLD;
    uMqm = MQM_AD;
    {uCin, uArLoad, uArxLoad, uBrLoad, uBrxLoad, uWl, uWr} = '0;
    uFmAddr = 4'd0;
  endtask

  task automatic checkValue(input string what, input logic [35:0] got, input logic [35:0] exp);
    assert (got === exp) else begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  // One APB transfer, sampled a little after the falling edge
  task automatic apbAccess(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           input logic expErr, output logic [31:0] rdata);
    int waits;
    int expWaits;
    @(negedge clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge clk);
    penable = 1'b1;
    waits = 0;
    #1;
    while (!pready && waits < APB_TIMEOUT) begin
      @(negedge clk);
      #1;
      waits++;
    end
    if (!pready) begin
      $display("APB transfer to address %h never completed, pready stayed low", addr);
      $display("tests failed");
      $finish;
    end else begin
      rdata = prdata;
      assert (pslverr === expErr) else begin
        $display("ERROR %0t: pslverr %b at address %h", $time, pslverr, addr);
        errorCount++;
      end
      expWaits = (write && addr == `EDP_REG_MICRO && !expErr) ? 1 : 0;
      assert (!walkDone || waits == expWaits) else begin
        $display("ERROR %0t: %0d wait states at address %h", $time, waits, addr);
        errorCount++;
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
    end
  endtask

  task automatic loadImm(input logic [35:0] v);
    logic [31:0] d;
    apbAccess(1'b1, `EDP_REG_IMM_LO, {14'd0, v[17:0]}, 1'b0, d);
    apbAccess(1'b1, `EDP_REG_IMM_HI, {14'd0, v[35:18]}, 1'b0, d);
    mImm = v;
  endtask

  // Model update from the values before the step edge, then the MICRO write
  task automatic doStep();
    logic [37:0] r;
    logic [35:0] ad, nAr, nArx, nMq, mqm;
    logic [31:0] d;
    r = refAlu(uOp, refAda(uAda), refAdb(uAdb, uFmAddr), uCin);
    ad = r[35:0];
    case (uArSel)
      AR_IMM:      nAr = mImm;
      AR_AD:       nAr = ad;
      AR_FM:       nAr = mFm[uFmAddr];
      AR_ARX:      nAr = mArx;
      AR_MQ:       nAr = mMq;
      AR_AD_LEFT:  nAr = {ad[34:0], 1'b0};
      AR_AD_RIGHT: nAr = {ad[35], ad[35:1]};
      default:     nAr = 36'd0;
    endcase
    case (uArxSel)
      ARX_IMM: nArx = mImm;
      ARX_AD:  nArx = ad;
      ARX_MQ:  nArx = mMq;
      default: nArx = 36'd0;
    endcase
    case (uMqm)
      MQM_AD:   mqm = ad;
      MQM_IMM:  mqm = mImm;
      MQM_ONES: mqm = '1;
      default:  mqm = mArx;
    endcase
    case (uMqOp)
      MQ_LOAD:        nMq = mqm;
      MQ_SHIFT_LEFT:  nMq = {mMq[34:0], r[37]};
      MQ_SHIFT_RIGHT: nMq = {mMq[35], mMq[35:1]};
      default:        nMq = mMq;
    endcase
    if (uWl) mFm[uFmAddr][35:18] = mAr[35:18];
    if (uWr) mFm[uFmAddr][17:0] = mAr[17:0];
    if (uBrLoad) mBr = mAr;
    if (uBrxLoad) mBrx = mArx;
    if (uArLoad) mAr = nAr;
    if (uArxLoad) mArx = nArx;
    mMq = nMq;
    {mCarry, mOvf} = r[37:36];
    mZero = (ad == 36'd0);
    {lastOp, lastAda, lastAdb, lastCin, lastFmAddr} = {uOp, uAda, uAdb, uCin, uFmAddr};
    apbAccess(1'b1, `EDP_REG_MICRO, packMicro(), 1'b0, d);
  endtask

  task automatic checkReg(input rdSel_t sel);
    logic [31:0] lo;
    logic [31:0] hi;
    apbAccess(1'b1, `EDP_REG_RDSEL, {29'd0, sel}, 1'b0, lo);
    apbAccess(1'b0, `EDP_REG_RD_LO, 32'd0, 1'b0, lo);
    apbAccess(1'b0, `EDP_REG_RD_HI, 32'd0, 1'b0, hi);
    assert (lo[31:18] == 14'd0 && hi[31:18] == 14'd0) else begin
      $display("ERROR %0t: readout of %s not zero-extended", $time, sel.name());
      errorCount++;
    end
    checkValue($sformatf("readout %s", sel.name()), {hi[17:0], lo[17:0]}, refReadout(sel));
  endtask

  task automatic checkStatus();
    logic [31:0] d;
    apbAccess(1'b0, `EDP_REG_STATUS, 32'd0, 1'b0, d);
    checkValue("status", {4'd0, d}, {32'd0, ^mFm[lastFmAddr], mZero, mOvf, mCarry});
  endtask

  task automatic checkAll();
    for (int s = 0; s < 7; s++) checkReg(rdSel_t'(s));
    checkStatus();
  endtask

  task automatic endTest(input string name);
    testsRun++;
    if (errorCount == testStartErrors) begin
      $display("test %0d %s: pass", testsRun, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: FAIL with %0d errors", testsRun, name, errorCount - testStartErrors);
    end
    testStartErrors = errorCount;
  endtask

  initial begin
    logic [35:0] a, b;
    logic [31:0] d;
    clk = 1'b0;
    rst = 1'b1;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {errorCount, testsRun, testsFailed, testStartErrors} = '0;
    walkDone = 1'b0;
    lcgState = 32'h98d4;
    {mAr, mArx, mBr, mBrx, mMq, mImm, mCarry, mOvf, mZero} = '0;
    for (int i = 0; i < 16; i++) mFm[i] = 36'd0;
    {lastOp, lastAda, lastAdb, lastCin, lastFmAddr} = {ALU_ADD, ADA_AR, ADB_FM, 1'b0, 4'd0};
    clearMicro();
    repeat (8) @(negedge clk);
    rst = 1'b0;

    // First access stalls through the FM clear walk
    apbAccess(1'b0, `EDP_REG_STATUS, 32'd0, 1'b0, d);
    walkDone = 1'b1;
    checkAll();
    endTest("reset state");

    a = randWord();
    b = randWord();
    loadImm(a);
    apbAccess(1'b0, `EDP_REG_IMM_HI, 32'd0, 1'b0, d);
    checkValue("imm high half", {4'd0, d}, {18'd0, a[35:18]});
    uArLoad = 1'b1;
    doStep();
    loadImm(b);
    {uArxSel, uArxLoad, uBrLoad, uBrxLoad} = {ARX_IMM, 3'b111};
    doStep();
    checkAll();
    endTest("register loads");

    for (int p = 0; p < 20; p++) begin
      a = randWord();
      b = (p == 0) ? a : randWord();
      loadImm(b);
      clearMicro();
      uArLoad = 1'b1;
      doStep();
      loadImm(a);
      uBrLoad = 1'b1;
      doStep();
      for (int k = 0; k < 8; k++) begin
        clearMicro();
        d = nextRand();
        uOp = aluOp_t'(k);
        uCin = d[31];
        doStep();
        checkReg(RD_AD);
        checkStatus();
      end
      clearMicro();
      {uOp, uArSel, uArLoad} = {ALU_ADD, AR_AD_LEFT, 1'b1};
      doStep();
      checkReg(RD_AR);
      {uOp, uArSel} = {ALU_PASS_A, AR_AD_RIGHT};
      doStep();
      checkReg(RD_AR);
      clearMicro();
      {uOp, uAdb} = {ALU_PASS_B, ADB_BR_X2};
      doStep();
      checkReg(RD_AD);
    end
    endTest("alu operations");

    loadImm(randWord());
    clearMicro();
    uArLoad = 1'b1;
    doStep();
    clearMicro();
    {uFmAddr, uWl} = {4'd3, 1'b1};
    doStep();
    checkReg(RD_FM);
    checkStatus();
    loadImm(randWord());
    clearMicro();
    uArLoad = 1'b1;
    doStep();
    clearMicro();
    {uFmAddr, uWr} = {4'd9, 1'b1};
    doStep();
    checkReg(RD_FM);
    {uFmAddr, uWr} = {4'd3, 1'b1};
    doStep();
    for (int i = 0; i < 2; i++) begin
      clearMicro();
      uFmAddr = (i == 0) ? 4'd3 : 4'd9;
      {uAdb, uOp, uArSel, uArLoad} = {ADB_FM, ALU_PASS_B, AR_AD, 1'b1};
      doStep();
      checkReg(RD_AR);
      checkReg(RD_FM);
      checkStatus();
    end
    endTest("fm halfword writes");

    clearMicro();
    loadImm(randWord());
    {uMqOp, uMqm} = {MQ_LOAD, MQM_IMM};
    doStep();
    checkReg(RD_MQ);
    uMqm = MQM_ONES;
    doStep();
    checkReg(RD_MQ);
    loadImm(randWord());
    {uArxSel, uArxLoad, uMqm} = {ARX_IMM, 1'b1, MQM_ARX};
    doStep();
    checkReg(RD_MQ);
    clearMicro();
    {uMqOp, uMqm, uOp} = {MQ_LOAD, MQM_AD, ALU_ADD};
    doStep();
    checkReg(RD_MQ);
    for (int k = 0; k < 6; k++) begin
      clearMicro();
      uMqOp = MQ_SHIFT_LEFT;
      uOp = k[0] ? ALU_SUB : ALU_ADD;
      uAdb = (k < 3) ? ADB_BR : ADB_ARX;
      doStep();
      checkReg(RD_MQ);
    end
    loadImm(randWord() | 36'h8_0000_0000);
    clearMicro();
    {uMqOp, uMqm} = {MQ_LOAD, MQM_IMM};
    doStep();
    for (int k = 0; k < 4; k++) begin
      uMqOp = MQ_SHIFT_RIGHT;
      doStep();
      checkReg(RD_MQ);
    end
    endTest("mq shifter");

    // Error transfers, one of them carrying a micro-word that would load everything
    clearMicro();
    {uArLoad, uArxLoad, uBrLoad, uBrxLoad, uMqOp, uArSel} = {4'hF, MQ_LOAD, AR_ZERO};
    apbAccess(1'b1, 8'h1C, packMicro(), 1'b1, d);
    apbAccess(1'b0, 8'h40, 32'd0, 1'b1, d);
    apbAccess(1'b1, `EDP_REG_STATUS, 32'hF, 1'b1, d);
    apbAccess(1'b1, `EDP_REG_RD_LO, 32'h3FFFF, 1'b1, d);
    apbAccess(1'b0, `EDP_REG_MICRO, 32'd0, 1'b1, d);
    checkAll();
    endTest("slave errors");

    $display("tests run %0d, with errors %0d, error count %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
source/edpPkg.sv
source/fastMemory.sv
source/adderUnit.sv
source/mqShifter.sv
source/registerPath.sv
source/edpControl.sv
source/edpTop.sv
sim/edpTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the EDP simulation with Verilator, run it, and check the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module edpTb -f vlog.f -o edpSim \
  && ./obj_dir/edpSim | tee sim.log \
  && grep -q "^all tests passed$" sim.log \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }
